//--- verilog/dcache_pkg.sv
package dcache_pkg;

    // Tie-break rule when both ways are valid and equally dirty.
    typedef enum logic {
        POLICY_RAND = 1'b0,
        POLICY_LRU  = 1'b1
    } repl_policy_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // Waiting for a request.
        EVICT  = 2'd1,  // Waiting for room in the eviction FIFO.
        REFILL = 2'd2,  // Waiting for the memory read.
        DONE   = 2'd3   // Response cycle.
    } ctrl_state_e;

    typedef struct packed {
        logic [31:0] addr;   // Word aligned.
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        write;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] addr;   // Word address of the line.
        logic [31:0] data;
        logic [3:0]  mask;   // Dirty bytes.
    } victim_t;

    // Size code is log2 of the byte count, so 0 byte, 1 halfword, 2 word.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  size;
    } bus_wr_t;

endpackage

//--- verilog/victim_select.sv
`timescale 1ns/1ns

module victim_select #(
    parameter dcache_pkg::repl_policy_e POLICY = dcache_pkg::POLICY_LRU
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       step,
    input  logic [1:0] way_v,
    input  logic [1:0] way_d,
    input  logic       lru,
    output logic [1:0] way_replace
);
    import dcache_pkg::*;

    logic [2:0] lfsr;
    logic       tie_way1;

    // Under LRU a set lru bit means way 0 is least recent.
    assign tie_way1 = (POLICY == POLICY_LRU) ? !lru : lfsr[0];

    always_comb begin
        case (way_v)
            2'b00, 2'b01: begin
                way_replace = 2'b10;  // Invalid way 1 goes first.
            end
            2'b10: begin
                way_replace = 2'b01;
            end
            default: begin
                case (way_d)
                    2'b01: begin
                        way_replace = 2'b10;  // Keep the dirty way.
                    end
                    2'b10: begin
                        way_replace = 2'b01;
                    end
                    default: begin
                        way_replace = tie_way1 ? 2'b10 : 2'b01;
                    end
                endcase
            end
        endcase
    end

    // LFSR on x^3 + x^2 + 1 with period 7.
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= 3'd1;
        end else if (step) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    a_replace_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot(way_replace));

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter int                       SET_BITS = 4,
    parameter dcache_pkg::repl_policy_e POLICY   = dcache_pkg::POLICY_LRU
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t cpu_req_data,
    output logic                 cpu_busy,
    output logic                 cpu_done,
    output logic [31:0]          cpu_rdata,
    output logic                 mem_rd_req,
    output logic [31:0]          mem_rd_addr,
    input  logic                 mem_rd_valid,
    input  logic [31:0]          mem_rd_data,
    output logic                 evict_push,
    output dcache_pkg::victim_t  evict_data,
    input  logic                 evict_full
);
    import dcache_pkg::*;

    localparam int SETS     = 1 << SET_BITS;
    localparam int TAG_BITS = 30 - SET_BITS;

    logic [TAG_BITS-1:0] tag_arr  [2][SETS];
    logic [31:0]         data_arr [2][SETS];
    logic [3:0]          mask_arr [2][SETS];
    logic [1:0]          valid_arr [SETS];  // One bit per way.
    logic [SETS-1:0]     lru_arr;

    ctrl_state_e         state;
    cpu_req_t            req_q;
    logic                way_q;
    logic                accept;
    logic [SET_BITS-1:0] req_set;
    logic [SET_BITS-1:0] fill_set;
    logic [TAG_BITS-1:0] req_tag;
    logic [1:0]          way_v;
    logic [1:0]          way_d;
    logic [1:0]          way_hit;
    logic [1:0]          way_replace;
    logic                hit_way;
    logic                vic_way;
    logic [3:0]          req_strb;
    logic [3:0]          fill_strb;
    logic [31:0]         hit_line;
    logic [31:0]         fill_line;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign accept   = cpu_req && state == IDLE;
    assign req_set  = cpu_req_data.addr[SET_BITS+1:2];
    assign req_tag  = cpu_req_data.addr[31:SET_BITS+2];
    assign fill_set = req_q.addr[SET_BITS+1:2];

    assign way_v      = valid_arr[req_set];
    assign way_d      = {|mask_arr[1][req_set], |mask_arr[0][req_set]};
    assign way_hit[0] = way_v[0] && tag_arr[0][req_set] == req_tag;
    assign way_hit[1] = way_v[1] && tag_arr[1][req_set] == req_tag;
    assign hit_way    = way_hit[1];
    assign vic_way    = way_replace[1];

    // Loads carry a zero strobe into the merge.
    assign req_strb  = cpu_req_data.strb & {4{cpu_req_data.write}};
    assign fill_strb = req_q.strb & {4{req_q.write}};
    assign hit_line  = merge_bytes(data_arr[hit_way][req_set], cpu_req_data.wdata, req_strb);
    assign fill_line = merge_bytes(mem_rd_data, req_q.wdata, fill_strb);

    assign cpu_busy    = state != IDLE;
    assign cpu_done    = state == DONE;
    assign evict_push  = state == EVICT && !evict_full;
    assign mem_rd_addr = req_q.addr;

    victim_select #(
        .POLICY(POLICY)
    ) victim_select_i (
        .clock      (clock),
        .reset      (reset),
        .step       (accept && way_hit == 2'b00),
        .way_v      (way_v),
        .way_d      (way_d),
        .lru        (lru_arr[req_set]),
        .way_replace(way_replace)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            mem_rd_req <= 1'b0;
            lru_arr    <= '0;
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s]   <= 2'b00;
                mask_arr[0][s] <= 4'b0000;
                mask_arr[1][s] <= 4'b0000;
            end
        end else begin
            mem_rd_req <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept && way_hit != 2'b00) begin
                        mask_arr[hit_way][req_set] <= mask_arr[hit_way][req_set] | req_strb;
                        lru_arr[req_set] <= hit_way;  // Other way becomes least recent.
                        state <= DONE;
                    end else if (accept && way_d[vic_way]) begin
                        state <= EVICT;
                    end else if (accept) begin
                        mem_rd_req <= 1'b1;
                        state      <= REFILL;
                    end
                end
                EVICT: begin
                    if (!evict_full) begin
                        mem_rd_req <= 1'b1;  // Read follows the push.
                        state      <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_rd_valid) begin
                        valid_arr[fill_set][way_q] <= 1'b1;
                        mask_arr[way_q][fill_set]  <= fill_strb;
                        lru_arr[fill_set]          <= way_q;
                        state                      <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q           <= cpu_req_data;
            way_q           <= vic_way;
            evict_data.addr <= {tag_arr[vic_way][req_set], req_set, 2'b00};
            evict_data.data <= data_arr[vic_way][req_set];
            evict_data.mask <= mask_arr[vic_way][req_set];
            if (way_hit != 2'b00) begin
                data_arr[hit_way][req_set] <= hit_line;
                cpu_rdata                  <= hit_line;
            end
        end
        if (state == REFILL && mem_rd_valid) begin
            tag_arr[way_q][fill_set]  <= req_q.addr[31:SET_BITS+2];
            data_arr[way_q][fill_set] <= fill_line;
            cpu_rdata                 <= fill_line;
        end
    end

    a_req_not_busy: assert property (@(posedge clock) disable iff (reset)
        cpu_req |-> !cpu_busy);

endmodule

//--- verilog/evict_fifo.sv
`timescale 1ns/1ns

module evict_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                push,
    input  dcache_pkg::victim_t push_data,
    input  logic                pop,
    output dcache_pkg::victim_t head,
    output logic                full,
    output logic                empty
);
    import dcache_pkg::*;

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    victim_t             entries [FIFO_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS:0]   count;

    assign head  = entries[rd_ptr];
    assign full  = count == (PTR_BITS + 1)'(FIFO_DEPTH);
    assign empty = count == '0;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (reset) push |-> !full);

    a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

endmodule

//--- verilog/mem_writer.sv
`timescale 1ns/1ns

module mem_writer (
    input  logic                clock,
    input  logic                reset,
    input  dcache_pkg::victim_t head,
    input  logic                empty,
    output logic                pop,
    output logic                mem_wr,
    output dcache_pkg::bus_wr_t mem_wr_data,
    input  logic                mem_busy
);
    import dcache_pkg::*;

    logic       loaded;     // Working mask belongs to the head entry.
    logic [3:0] mask_left;
    logic [3:0] cur_mask;
    logic [3:0] covered;
    logic [3:0] rest;
    logic [1:0] offset;
    logic       issue;
    bus_wr_t    wr_next;

    assign cur_mask = loaded ? mask_left : head.mask;
    assign issue    = !empty && !mem_busy;

    always_comb begin
        if (cur_mask[0]) begin
            offset = 2'd0;
        end else if (cur_mask[1]) begin
            offset = 2'd1;
        end else if (cur_mask[2]) begin
            offset = 2'd2;
        end else begin
            offset = 2'd3;
        end

        wr_next.addr = {head.addr[31:2], offset};
        wr_next.data = head.data;
        wr_next.size = 2'd0;
        case (offset)
            2'd0: begin
                if (cur_mask[3]) begin
                    wr_next.size = 2'd2;
                end else if (cur_mask[1]) begin
                    wr_next.size = 2'd1;
                end
            end
            2'd2: begin
                if (cur_mask[3]) begin
                    wr_next.size = 2'd1;
                end
            end
            default: begin
                wr_next.size = 2'd0;  // Odd offsets take a byte.
            end
        endcase

        case (wr_next.size)
            2'd2:    covered = 4'b1111;
            2'd1:    covered = 4'b0011 << offset;
            default: covered = 4'b0001 << offset;
        endcase
        rest = cur_mask & ~covered;
    end

    assign mem_wr      = issue && cur_mask != 4'b0000;
    assign mem_wr_data = wr_next;
    assign pop         = issue && rest == 4'b0000;

    always_ff @(posedge clock) begin
        if (reset) begin
            loaded    <= 1'b0;
            mask_left <= 4'b0000;
        end else if (issue) begin
            loaded    <= rest != 4'b0000;
            mask_left <= rest;
        end
    end

    a_wr_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_wr |-> (mem_wr_data.size == 2'd0)
                || (mem_wr_data.size == 2'd1 && !mem_wr_data.addr[0])
                || (mem_wr_data.size == 2'd2 && mem_wr_data.addr[1:0] == 2'b00));

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
    parameter int                       SET_BITS   = 4,
    parameter dcache_pkg::repl_policy_e POLICY     = dcache_pkg::POLICY_LRU,
    parameter int                       FIFO_DEPTH = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t cpu_req_data,
    output logic                 cpu_busy,
    output logic                 cpu_done,
    output logic [31:0]          cpu_rdata,
    output logic                 mem_rd_req,
    output logic [31:0]          mem_rd_addr,
    input  logic                 mem_rd_valid,
    input  logic [31:0]          mem_rd_data,
    output logic                 mem_wr,
    output dcache_pkg::bus_wr_t  mem_wr_data,
    input  logic                 mem_busy
);
    import dcache_pkg::*;

    logic    evict_push;
    logic    evict_pop;
    logic    evict_full;
    logic    evict_empty;
    victim_t evict_data;
    victim_t evict_head;

    dcache_ctrl #(
        .SET_BITS(SET_BITS),
        .POLICY  (POLICY)
    ) dcache_ctrl_i (
        .clock       (clock),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_req_data(cpu_req_data),
        .cpu_busy    (cpu_busy),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data (mem_rd_data),
        .evict_push  (evict_push),
        .evict_data  (evict_data),
        .evict_full  (evict_full)
    );

    evict_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) evict_fifo_i (
        .clock    (clock),
        .reset    (reset),
        .push     (evict_push),
        .push_data(evict_data),
        .pop      (evict_pop),
        .head     (evict_head),
        .full     (evict_full),
        .empty    (evict_empty)
    );

    mem_writer mem_writer_i (
        .clock      (clock),
        .reset      (reset),
        .head       (evict_head),
        .empty      (evict_empty),
        .pop        (evict_pop),
        .mem_wr     (mem_wr),
        .mem_wr_data(mem_wr_data),
        .mem_busy   (mem_busy)
    );

endmodule

//--- sim/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic        clock;
    logic        reset;
    logic        cpu_req;
    cpu_req_t    cpu_req_data;
    logic        cpu_busy;
    logic        cpu_done;
    logic [31:0] cpu_rdata;
    logic        mem_rd_req;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_valid = 1'b0;
    logic [31:0] mem_rd_data  = 32'h0;
    logic        mem_wr;
    bus_wr_t     mem_wr_data;
    logic        mem_busy;

    logic [7:0]  ref_mem [logic [31:0]];  // Bytes written back by the DUT.
    logic [31:0] shadow [logic [31:0]];   // CPU view by word address.
    bus_wr_t     wr_log [$];
    logic [15:0] lat_lfsr;
    logic [15:0] data_lfsr;
    logic [31:0] rd_addr;
    int          rd_wait  = 0;
    int          rd_count = 0;
    int          errors;
    int          checks;
    int          tests;

    dcache_top #(
        .SET_BITS  (4),
        .POLICY    (POLICY_LRU),
        .FIFO_DEPTH(4)
    ) dcache_top_i (
        .clock       (clock),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_req_data(cpu_req_data),
        .cpu_busy    (cpu_busy),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data (mem_rd_data),
        .mem_wr      (mem_wr),
        .mem_wr_data (mem_wr_data),
        .mem_busy    (mem_busy)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit taken.
    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits  = {bits[30:0], state[15]};
            state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_1e0f;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] word;
        word = fill_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(addr + b)) begin
                word[b*8 +: 8] = ref_mem[addr + b];
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    // Expected cpu_rdata for one access.
    function automatic logic [31:0] predict(input logic [31:0] addr, input logic [31:0] wdata,
                                            input logic [3:0] strb, input logic write);
        if (!shadow.exists(addr)) begin
            shadow[addr] = mem_word(addr);
        end
        if (write) begin
            shadow[addr] = apply_strobe(shadow[addr], wdata, strb);
        end
        return shadow[addr];
    endfunction

    function automatic logic [31:0] random_word();
        return take_bits(data_lfsr, 32);
    endfunction

    // Memory model logging bus writes and answering reads after 1 to 4 cycles.
    always @(posedge clock) begin
        if (reset) begin
            mem_rd_valid <= 1'b0;
            rd_wait      <= 0;
        end else begin
            mem_rd_valid <= 1'b0;
            if (mem_wr) begin
                wr_log.push_back(mem_wr_data);
                for (int b = 0; b < (1 << mem_wr_data.size); b++) begin
                    ref_mem[mem_wr_data.addr + b] =
                        mem_wr_data.data[(mem_wr_data.addr[1:0] + b) * 8 +: 8];
                end
            end
            if (rd_wait == 1) begin
                mem_rd_valid <= 1'b1;
                mem_rd_data  <= mem_word(rd_addr);
            end
            if (rd_wait > 0) begin
                rd_wait <= rd_wait - 1;
            end
            if (mem_rd_req) begin
                rd_addr  <= mem_rd_addr;
                rd_wait  <= 1 + int'(take_bits(lat_lfsr, 2));
                rd_count <= rd_count + 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic write);
        cpu_req_t req;
        req.addr  = addr;
        req.wdata = wdata;
        req.strb  = strb;
        req.write = write;
        @(posedge clock);
        cpu_req      <= 1'b1;
        cpu_req_data <= req;
        @(posedge clock);
        cpu_req <= 1'b0;
    endtask

    task automatic wait_done(input int limit, output logic ok);
        int n;
        n = 0;
        @(negedge clock);
        while (!cpu_done && n < limit) begin
            @(negedge clock);
            n++;
        end
        ok = cpu_done;
    endtask

    task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, input logic write);
        logic        ok;
        logic [31:0] expected;
        expected = predict(addr, wdata, strb, write);
        send_req(addr, wdata, strb, write);
        wait_done(WAIT_LIMIT, ok);
        if (!ok) begin
            errors++;
            $display("Timeout at %0t ns: no cpu_done for address %h", $time, addr);
        end else begin
            check_value("cpu_rdata", cpu_rdata, expected);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clock);
        while (!dcache_top_i.evict_empty && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!dcache_top_i.evict_empty) begin
            errors++;
            $display("Timeout at %0t ns: eviction FIFO never drained", $time);
        end
    endtask

    task automatic check_write(input int idx, input logic [31:0] addr, input logic [1:0] size);
        if (idx < wr_log.size()) begin
            check_value("mem_wr_data.addr", wr_log[idx].addr, addr);
            check_value("mem_wr_data.size", 32'(wr_log[idx].size), 32'(size));
            check_value("mem_wr_data.data", wr_log[idx].data, shadow[{addr[31:2], 2'b00}]);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic load_refill();
        int e0;
        int reads0;
        e0     = errors;
        reads0 = rd_count;
        access(32'h0000_1000, 32'h0, 4'h0, 1'b0);
        check_value("mem_rd_count", 32'(rd_count - reads0), 32'd1);
        access(32'h0000_1000, 32'h0, 4'h0, 1'b0);  // Hit needs no second read.
        check_value("mem_rd_count", 32'(rd_count - reads0), 32'd1);
        finish_test("load_refill", e0);
    endtask

    task automatic store_merge();
        int e0;
        e0 = errors;
        access(32'h0000_1104, 32'h1122_33ab, 4'b0001, 1'b1);
        access(32'h0000_1104, 32'hcdef_0000, 4'b1100, 1'b1);
        access(32'h0000_1104, 32'h0, 4'h0, 1'b0);
        access(32'h0000_1130, 32'h9999_5a3c, 4'b0011, 1'b1);
        access(32'h0000_1130, 32'h0, 4'h0, 1'b0);
        finish_test("store_merge", e0);
    endtask

    task automatic lru_evict();
        int e0;
        e0 = errors;
        wait_drain();
        wr_log.delete();
        access(32'h0000_2008, random_word(), 4'hf, 1'b1);
        access(32'h0000_2048, random_word(), 4'hf, 1'b1);
        access(32'h0000_2008, 32'h0, 4'h0, 1'b0);
        access(32'h0000_2048, 32'h0, 4'h0, 1'b0);  // Touched line stays.
        access(32'h0000_2088, random_word(), 4'hf, 1'b1);
        wait_drain();
        check_value("write count", wr_log.size(), 32'd1);
        check_write(0, 32'h0000_2008, 2'd2);
        finish_test("lru_evict", e0);
    endtask

    // Dirty line at base, then two dirty lines push it out.
    task automatic evict_line(input logic [31:0] base, input logic [3:0] strb);
        wait_drain();
        wr_log.delete();
        access(base, random_word(), strb, 1'b1);
        access(base + 32'h40, random_word(), 4'hf, 1'b1);
        access(base + 32'h80, random_word(), 4'hf, 1'b1);
        wait_drain();
    endtask

    task automatic write_sizes();
        int e0;
        e0 = errors;
        evict_line(32'h0000_4010, 4'b0110);
        check_value("write count", wr_log.size(), 32'd2);
        check_write(0, 32'h0000_4011, 2'd0);
        check_write(1, 32'h0000_4012, 2'd0);
        evict_line(32'h0000_4014, 4'b1111);
        check_value("write count", wr_log.size(), 32'd1);
        check_write(0, 32'h0000_4014, 2'd2);
        evict_line(32'h0000_4018, 4'b1100);
        check_value("write count", wr_log.size(), 32'd1);
        check_write(0, 32'h0000_401a, 2'd1);
        finish_test("write_sizes", e0);
    endtask

    task automatic backpressure_fill();
        int          e0;
        logic        ok;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic [3:0]  strb;
        e0 = errors;
        wait_drain();
        @(posedge clock);
        mem_busy <= 1'b1;
        for (int k = 0; k < 7; k++) begin
            addr  = 32'h0000_5024 + 32'(k * 64);
            wdata = random_word();
            strb  = 4'(take_bits(data_lfsr, 4));
            if (strb == 4'h0) begin
                strb = 4'h8;
            end
            if (k < 6) begin
                access(addr, wdata, strb, 1'b1);
            end else begin
                // Four dirty victims fill the FIFO, so this one stalls.
                expected = predict(addr, wdata, strb, 1'b1);
                send_req(addr, wdata, strb, 1'b1);
                wait_done(20, ok);
                check_value("cpu_done", 32'(ok), 32'd0);
                check_value("cpu_busy", 32'(cpu_busy), 32'd1);
                @(posedge clock);
                mem_busy <= 1'b0;
                wait_done(WAIT_LIMIT, ok);
                if (!ok) begin
                    errors++;
                    $display("Timeout at %0t ns: stalled miss never completed", $time);
                end else begin
                    check_value("cpu_rdata", cpu_rdata, expected);
                end
            end
        end
        wait_drain();
        finish_test("backpressure", e0);
    endtask

    task automatic eviction_sweep();
        int e0;
        e0 = errors;
        for (int s = 0; s < 16; s++) begin
            access(32'hf000_0000 + 32'(s * 4), random_word(), 4'hf, 1'b1);
            access(32'hf000_0040 + 32'(s * 4), random_word(), 4'hf, 1'b1);
        end
        wait_drain();
        foreach (shadow[a]) begin
            if (a[31:28] != 4'hf) begin  // Sweep lines stay cached.
                check_value("memory word", mem_word(a), shadow[a]);
            end
        end
        finish_test("sweep", e0);
    endtask

    initial begin
        lat_lfsr     = 16'd9518;
        data_lfsr    = 16'd9518;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        reset        = 1'b1;
        cpu_req      = 1'b0;
        cpu_req_data = '0;
        mem_busy     = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        load_refill();
        store_merge();
        lru_evict();
        write_sizes();
        backpressure_fill();
        eviction_sweep();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/dcache_pkg.sv
verilog/victim_select.sv
verilog/dcache_ctrl.sv
verilog/evict_fifo.sv
verilog/mem_writer.sv
verilog/dcache_top.sv
sim/dcache_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the dcache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
    -f vlog.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
